//--- hw/ads_params.svh
`ifndef ADS_PARAMS_SVH
`define ADS_PARAMS_SVH

// spi clock, system clocks per half sclk period
`define ADS_CLKS_PER_HALF_BIT 2

// power-up waits, short values for simulation
`define ADS_POR_CYCLES 200 // reset pin high before the pulse
`define ADS_RESET_CYCLES 40 // pulse width, also the wait after it

// chip select and drdy timing
`define ADS_CS_HOLD_CYCLES 16 // last byte to csn high
`define ADS_DRDY_GAP_CYCLES 8 // drdy fall to first sclk

// continuous read
`define ADS_SETTLE_DRDY 3 // unsettled drdy pulses to skip
`define ADS_FRAME_BYTES 9 // status + ch1 + ch2, 3 bytes each

`define ADS_WAIT_W 16 // wait counter width

`endif

//--- hw/ads_frame_pkg.sv
`default_nettype none

package ads_frame_pkg;

	typedef logic [7:0] byte_t;

	// one rdatac frame as it comes off DOUT, status first
	typedef struct packed {
		logic [23:0] status; // 1100 + loff bits + gpio
		logic [23:0] ch1;    // two's complement
		logic [23:0] ch2;
	} ads_frame_t;

endpackage

`default_nettype wire

//--- hw/ads_cmd_pkg.sv
`default_nettype none

package ads_cmd_pkg;

	// host control code on i_ctrl, a level
	typedef enum logic [2:0] {
		CTRL_IDLE   = 3'b000,
		CTRL_WREG   = 3'b010,
		CTRL_RREG   = 3'b011,
		CTRL_RDATAC = 3'b100,
		CTRL_SDATAC = 3'b101
	} ctrl_e;

	// first opcode byte is {op, addr[4:0]}
	localparam logic [2:0] OP_RREG = 3'b001;
	localparam logic [2:0] OP_WREG = 3'b010;

	// single byte commands
	localparam logic [7:0] CM_RDATAC = 8'h10;
	localparam logic [7:0] CM_SDATAC = 8'h11;

	typedef enum logic [3:0] {
		ST_POR,       // resetn high, power-on wait
		ST_RST_PULSE, // resetn low
		ST_RST_WAIT,  // wait after the pulse
		ST_STANDBY,   // ready for a code
		ST_SHIFT,     // send the byte list of r_op
		ST_CS_HOLD,   // hold csn low after the last byte
		ST_RELEASE,   // wait for i_ctrl back to idle
		ST_RD_WAIT,   // continuous read, wait for drdy fall
		ST_RD_GAP,    // drdy fall to first sclk
		ST_RD_FRAME,  // dummy bytes until the frame is in
		ST_SD_WAIT    // stop requested, wait for drdy high
	} seq_state_e;

endpackage

`default_nettype wire

//--- hw/spi_byte_if.sv
`timescale 1ns/1ps
`default_nettype none

// byte transfers between the sequencer and the spi shifter
interface spi_byte_if;

	ads_frame_pkg::byte_t tx_byte; // held by ctl while tx_valid
	logic tx_valid; // one cycle, only while tx_ready
	logic tx_ready; // shifter idle
	ads_frame_pkg::byte_t rx_byte; // last byte in from MISO
	logic rx_valid; // one cycle per transfer

	modport ctl (
		output tx_byte, tx_valid,
		input  tx_ready, rx_byte, rx_valid
	);

	modport phy (
		input  tx_byte, tx_valid,
		output tx_ready, rx_byte, rx_valid
	);

	modport mon (
		input rx_byte, rx_valid
	);

endinterface

`default_nettype wire

//--- hw/spi_master.sv
`timescale 1ns/1ps
`default_nettype none
`include "ads_params.svh"

// spi mode 1 byte shifter
// cpol 0, mosi changes on rising sclk, miso sampled on falling sclk
module spi_master (
	input  logic i_CLK,
	input  logic i_RSTN,
	spi_byte_if.phy bus,
	output logic o_sclk,
	output logic o_mosi,
	input  logic i_miso
);

	localparam int HALF_W = $clog2(`ADS_CLKS_PER_HALF_BIT + 1);
	localparam logic [HALF_W-1:0] HALF_LAST = HALF_W'(`ADS_CLKS_PER_HALF_BIT - 1);

	// 16 sclk edges then half a bit of trailing time, counted down
	localparam logic [4:0] EDGES_TOTAL = 5'd17;

	logic [HALF_W-1:0] r_half_cnt;
	logic [4:0] r_edge_cnt; // 0 means idle
	logic [7:0] r_tx_shift;
	logic [7:0] r_rx_shift;
	logic r_sclk;
	logic w_start;
	logic w_tick; // end of a half bit
	logic w_edge; // a real sclk edge on this tick

	assign w_start = bus.tx_valid && bus.tx_ready;
	assign w_tick = (r_half_cnt == HALF_LAST);
	assign w_edge = w_tick && (r_edge_cnt > 5'd1);

	assign bus.tx_ready = (r_edge_cnt == 5'd0);
	assign bus.rx_byte = r_rx_shift;
	assign o_sclk = r_sclk;

	// ==================================================
	// clock divider and edge sequencing
	// ==================================================
	always_ff @(posedge i_CLK or negedge i_RSTN) begin
		if (!i_RSTN) begin
			r_half_cnt <= '0;
			r_edge_cnt <= '0;
			r_sclk <= 1'b0; // idles low
			o_mosi <= 1'b0;
			bus.rx_valid <= 1'b0;
		end else begin
			bus.rx_valid <= 1'b0;
			if (w_start) begin
				r_edge_cnt <= EDGES_TOTAL;
				r_half_cnt <= '0;
			end else if (r_edge_cnt != 5'd0) begin
				r_half_cnt <= w_tick ? '0 : r_half_cnt + 1'b1;
				if (w_tick)
					r_edge_cnt <= r_edge_cnt - 1'b1;
				if (w_edge) begin
					r_sclk <= ~r_sclk;
					if (r_edge_cnt[0]) // odd count, rising edge
						o_mosi <= r_tx_shift[7];
				end
				if (w_tick && r_edge_cnt == 5'd2) // last falling edge
					bus.rx_valid <= 1'b1;
			end
		end
	end

	// shift registers, msb first
	always_ff @(posedge i_CLK) begin
		if (w_start) begin
			r_tx_shift <= bus.tx_byte;
		end else if (w_edge) begin
			if (r_edge_cnt[0])
				r_tx_shift <= {r_tx_shift[6:0], 1'b0};
			else
				r_rx_shift <= {r_rx_shift[6:0], i_miso}; // falling edge sample
		end
	end

	// the sequencer must drop tx_valid after one handshake
	a_valid_needs_ready: assert property (@(posedge i_CLK) disable iff (!i_RSTN)
		bus.tx_valid |-> bus.tx_ready)
		else $error("spi_master: tx_valid while busy");

endmodule

`default_nettype wire

//--- hw/ads_frame_capture.sv
`timescale 1ns/1ps
`default_nettype none
`include "ads_params.svh"

// assembles one rdatac frame from the received byte stream
module ads_frame_capture (
	input  logic i_CLK,
	input  logic i_RSTN,
	spi_byte_if.mon bus,
	input  logic i_capture, // high throughout continuous read
	output ads_frame_pkg::ads_frame_t o_frame,
	output logic o_frame_done
);

	localparam int FRAME_W = 8 * `ADS_FRAME_BYTES;
	localparam logic [3:0] LAST_BYTE = 4'(`ADS_FRAME_BYTES - 1);

	logic [3:0] r_byte_cnt;
	logic [FRAME_W-9:0] r_shift; // bytes before the last one
	logic w_take;
	logic w_last;

	assign w_take = i_capture && bus.rx_valid;
	assign w_last = (r_byte_cnt == LAST_BYTE);

	always_ff @(posedge i_CLK or negedge i_RSTN) begin
		if (!i_RSTN) begin
			r_byte_cnt <= '0;
			o_frame_done <= 1'b0;
		end else begin
			o_frame_done <= 1'b0;
			if (!i_capture) begin
				r_byte_cnt <= '0; // stray bytes outside a read don't count
			end else if (bus.rx_valid) begin
				if (w_last) begin
					r_byte_cnt <= '0;
					o_frame_done <= 1'b1;
				end else begin
					r_byte_cnt <= r_byte_cnt + 1'b1;
				end
			end
		end
	end

	// first byte ends up in the status field
	always_ff @(posedge i_CLK) begin
		if (w_take) begin
			r_shift <= {r_shift[FRAME_W-17:0], bus.rx_byte};
			if (w_last)
				o_frame <= ads_frame_pkg::ads_frame_t'({r_shift, bus.rx_byte});
		end
	end

	a_done_in_capture: assert property (@(posedge i_CLK) disable iff (!i_RSTN)
		o_frame_done |-> $past(i_capture))
		else $error("ads_frame_capture: frame done outside capture");

endmodule

`default_nettype wire

//--- hw/ads_sequencer.sv
`timescale 1ns/1ps
`default_nettype none
`include "ads_params.svh"

// power-up, register access and continuous read sequencing
module ads_sequencer (
	input  logic i_CLK,
	input  logic i_RSTN,
	input  ads_cmd_pkg::ctrl_e i_ctrl,
	input  ads_frame_pkg::byte_t i_reg_addr,
	input  ads_frame_pkg::byte_t i_reg_wdata,
	spi_byte_if.ctl bus,
	input  logic i_frame_done,
	input  logic i_drdy_n,
	output logic o_capture,
	output ads_frame_pkg::byte_t o_reg_rdata,
	output logic o_busy,
	output logic o_init_done,
	output logic o_spi_csn,
	output logic o_ads_resetn,
	output logic o_ads_start
);

	localparam int WAIT_W = `ADS_WAIT_W;
	localparam logic [WAIT_W-1:0] POR_LAST = WAIT_W'(`ADS_POR_CYCLES - 1);
	localparam logic [WAIT_W-1:0] RST_LAST = WAIT_W'(`ADS_RESET_CYCLES - 1);
	localparam logic [WAIT_W-1:0] HOLD_LAST = WAIT_W'(`ADS_CS_HOLD_CYCLES - 1);
	localparam logic [WAIT_W-1:0] GAP_LAST = WAIT_W'(`ADS_DRDY_GAP_CYCLES - 1);
	localparam logic [7:0] SETTLE_N = 8'(`ADS_SETTLE_DRDY);

	ads_cmd_pkg::seq_state_e r_state;
	ads_cmd_pkg::ctrl_e r_op; // operation whose bytes are sent
	logic [1:0] r_idx; // bytes handed to the shifter
	logic [1:0] w_nbytes;
	logic [WAIT_W-1:0] r_wait;
	logic [WAIT_W-1:0] w_wait_last;
	logic w_waiting;
	logic w_wait_done;
	logic [7:0] r_settle; // drdy falls skipped so far
	logic r_drdy_s; // drdy synchronizer
	logic r_drdy_q;
	logic w_drdy_fall;
	ads_frame_pkg::byte_t r_addr;
	ads_frame_pkg::byte_t r_wdata;

	// byte idx of the command list for op
	function automatic ads_frame_pkg::byte_t seq_byte(
		input ads_cmd_pkg::ctrl_e op,
		input logic [1:0] idx,
		input ads_frame_pkg::byte_t addr,
		input ads_frame_pkg::byte_t wdata
	);
		ads_frame_pkg::byte_t b;
		case (op)
			ads_cmd_pkg::CTRL_WREG:
				if (idx == 2'd0)
					b = {ads_cmd_pkg::OP_WREG, addr[4:0]};
				else if (idx == 2'd1)
					b = 8'h00; // count, one register
				else
					b = wdata;
			ads_cmd_pkg::CTRL_RREG:
				if (idx == 2'd0)
					b = {ads_cmd_pkg::OP_RREG, addr[4:0]};
				else
					b = 8'h00; // count, then dummy
			ads_cmd_pkg::CTRL_RDATAC: b = ads_cmd_pkg::CM_RDATAC;
			default: b = ads_cmd_pkg::CM_SDATAC;
		endcase
		return b;
	endfunction

	assign w_nbytes = (r_op == ads_cmd_pkg::CTRL_WREG || r_op == ads_cmd_pkg::CTRL_RREG) ?
		2'd3 : 2'd1;

	assign o_capture = (r_state == ads_cmd_pkg::ST_RD_WAIT) ||
		(r_state == ads_cmd_pkg::ST_RD_GAP) || (r_state == ads_cmd_pkg::ST_RD_FRAME);

	// dummy bytes while reading frames
	assign bus.tx_byte = o_capture ? 8'h00 : seq_byte(r_op, r_idx, r_addr, r_wdata);

	// ==================================================
	// drdy edge and wait counter
	// ==================================================
	assign w_drdy_fall = r_drdy_q && !r_drdy_s;

	always_ff @(posedge i_CLK or negedge i_RSTN) begin
		if (!i_RSTN) begin
			r_drdy_s <= 1'b1;
			r_drdy_q <= 1'b1;
		end else begin
			r_drdy_s <= i_drdy_n;
			r_drdy_q <= r_drdy_s;
		end
	end

	always_comb begin
		w_wait_last = '0;
		w_waiting = 1'b1;
		case (r_state)
			ads_cmd_pkg::ST_POR: w_wait_last = POR_LAST;
			ads_cmd_pkg::ST_RST_PULSE,
			ads_cmd_pkg::ST_RST_WAIT: w_wait_last = RST_LAST;
			ads_cmd_pkg::ST_CS_HOLD: w_wait_last = HOLD_LAST;
			ads_cmd_pkg::ST_RD_GAP: w_wait_last = GAP_LAST;
			default: w_waiting = 1'b0;
		endcase
	end

	assign w_wait_done = w_waiting && (r_wait == w_wait_last);

	// cleared between waits, so back to back wait states each start at 0
	always_ff @(posedge i_CLK or negedge i_RSTN) begin
		if (!i_RSTN)
			r_wait <= '0;
		else if (w_wait_done || !w_waiting)
			r_wait <= '0;
		else
			r_wait <= r_wait + 1'b1;
	end

	// ==================================================
	// main FSM
	// ==================================================
	always_ff @(posedge i_CLK or negedge i_RSTN) begin
		if (!i_RSTN) begin
			r_state <= ads_cmd_pkg::ST_POR;
			r_op <= ads_cmd_pkg::CTRL_IDLE;
			r_idx <= '0;
			r_settle <= '0;
			bus.tx_valid <= 1'b0;
			o_busy <= 1'b0;
			o_init_done <= 1'b0;
			o_spi_csn <= 1'b1;
			o_ads_resetn <= 1'b1; // held high through power-on wait
			o_ads_start <= 1'b0;
		end else begin
			case (r_state)
				ads_cmd_pkg::ST_POR:
					if (w_wait_done) begin
						o_ads_resetn <= 1'b0;
						r_state <= ads_cmd_pkg::ST_RST_PULSE;
					end
				ads_cmd_pkg::ST_RST_PULSE:
					if (w_wait_done) begin
						o_ads_resetn <= 1'b1;
						r_state <= ads_cmd_pkg::ST_RST_WAIT;
					end
				ads_cmd_pkg::ST_RST_WAIT:
					if (w_wait_done) begin // chip wakes in rdatac, stop it
						r_op <= ads_cmd_pkg::CTRL_SDATAC;
						r_idx <= '0;
						o_spi_csn <= 1'b0;
						r_state <= ads_cmd_pkg::ST_SHIFT;
					end
				ads_cmd_pkg::ST_STANDBY:
					if (i_ctrl inside {ads_cmd_pkg::CTRL_WREG, ads_cmd_pkg::CTRL_RREG,
						ads_cmd_pkg::CTRL_RDATAC, ads_cmd_pkg::CTRL_SDATAC}) begin
						r_op <= i_ctrl;
						r_idx <= '0;
						r_settle <= '0;
						o_busy <= 1'b1;
						o_spi_csn <= 1'b0;
						o_ads_start <= (i_ctrl == ads_cmd_pkg::CTRL_RDATAC); // start by pin
						r_state <= ads_cmd_pkg::ST_SHIFT;
					end
				ads_cmd_pkg::ST_SHIFT:
					if (bus.tx_valid) begin // handshake this cycle
						bus.tx_valid <= 1'b0;
						r_idx <= r_idx + 1'b1;
					end else if (bus.tx_ready) begin
						if (r_idx != w_nbytes) begin
							bus.tx_valid <= 1'b1;
						end else if (r_op == ads_cmd_pkg::CTRL_RDATAC) begin
							r_state <= ads_cmd_pkg::ST_RD_WAIT;
						end else begin
							if (r_op == ads_cmd_pkg::CTRL_SDATAC)
								o_ads_start <= 1'b0; // conversions off
							r_state <= ads_cmd_pkg::ST_CS_HOLD;
						end
					end
				ads_cmd_pkg::ST_CS_HOLD:
					if (w_wait_done) begin
						o_spi_csn <= 1'b1;
						o_busy <= 1'b0;
						o_init_done <= 1'b1; // first pass ends power-up
						r_state <= ads_cmd_pkg::ST_RELEASE;
					end
				ads_cmd_pkg::ST_RELEASE:
					if (i_ctrl == ads_cmd_pkg::CTRL_IDLE)
						r_state <= ads_cmd_pkg::ST_STANDBY;
				ads_cmd_pkg::ST_RD_WAIT:
					if (i_ctrl == ads_cmd_pkg::CTRL_SDATAC) begin
						r_state <= ads_cmd_pkg::ST_SD_WAIT;
					end else if (w_drdy_fall) begin
						if (r_settle == SETTLE_N)
							r_state <= ads_cmd_pkg::ST_RD_GAP;
						else
							r_settle <= r_settle + 1'b1; // unsettled, skip
					end
				ads_cmd_pkg::ST_RD_GAP:
					if (w_wait_done)
						r_state <= ads_cmd_pkg::ST_RD_FRAME;
				ads_cmd_pkg::ST_RD_FRAME:
					if (i_frame_done)
						r_state <= ads_cmd_pkg::ST_RD_WAIT; // capture counted the bytes
					else if (bus.tx_valid)
						bus.tx_valid <= 1'b0;
					else if (bus.tx_ready)
						bus.tx_valid <= 1'b1;
				ads_cmd_pkg::ST_SD_WAIT:
					if (r_drdy_q) begin // keep clear of the drdy pulse
						r_op <= ads_cmd_pkg::CTRL_SDATAC;
						r_idx <= '0;
						r_state <= ads_cmd_pkg::ST_SHIFT;
					end
				default: r_state <= ads_cmd_pkg::ST_POR;
			endcase
		end
	end

	// operands held for the whole transfer, read result from the dummy byte
	always_ff @(posedge i_CLK) begin
		if (r_state == ads_cmd_pkg::ST_STANDBY) begin
			r_addr <= i_reg_addr;
			r_wdata <= i_reg_wdata;
		end
		if (r_state == ads_cmd_pkg::ST_SHIFT && r_op == ads_cmd_pkg::CTRL_RREG &&
			bus.rx_valid && r_idx == 2'd3)
			o_reg_rdata <= bus.rx_byte;
	end

	a_csn_idle: assert property (@(posedge i_CLK) disable iff (!i_RSTN)
		(o_init_done && !o_busy) |-> o_spi_csn)
		else $error("ads_sequencer: csn low while idle");

	// once up, the chip is never reset again
	a_reset_once: assert property (@(posedge i_CLK) disable iff (!i_RSTN)
		o_init_done |=> (o_init_done && o_ads_resetn))
		else $error("ads_sequencer: reset pin low after init");

endmodule

`default_nettype wire

//--- hw/ads1292_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

// ADS1292 controller, host side and chip side pins
module ads1292_ctrl_top (
	input  logic i_CLK,
	input  logic i_RSTN,
	input  logic [2:0] i_ctrl,
	input  logic [7:0] i_reg_addr,
	input  logic [7:0] i_reg_wdata,
	output logic [7:0] o_reg_rdata,
	output logic [71:0] o_frame, // status, ch1, ch2
	output logic o_data_valid, // one cycle per frame, no back-pressure
	output logic o_busy,
	output logic o_init_done,
	output logic o_spi_clk,
	output logic o_spi_mosi,
	input  logic i_spi_miso,
	output logic o_spi_csn,
	input  logic i_drdy_n,
	output logic o_ads_resetn,
	output logic o_ads_start
);

	spi_byte_if u_bus ();

	ads_frame_pkg::ads_frame_t w_frame;
	logic w_frame_done;
	logic w_capture;

	assign o_frame = w_frame;
	assign o_data_valid = w_frame_done;

	spi_master u_spi (
		.i_CLK (i_CLK),
		.i_RSTN (i_RSTN),
		.bus (u_bus.phy),
		.o_sclk (o_spi_clk),
		.o_mosi (o_spi_mosi),
		.i_miso (i_spi_miso)
	);

	ads_frame_capture u_capture (
		.i_CLK (i_CLK),
		.i_RSTN (i_RSTN),
		.bus (u_bus.mon),
		.i_capture (w_capture),
		.o_frame (w_frame),
		.o_frame_done (w_frame_done)
	);

	ads_sequencer u_seq (
		.i_CLK (i_CLK),
		.i_RSTN (i_RSTN),
		.i_ctrl (ads_cmd_pkg::ctrl_e'(i_ctrl)), // unlisted codes are ignored
		.i_reg_addr (i_reg_addr),
		.i_reg_wdata (i_reg_wdata),
		.bus (u_bus.ctl),
		.i_frame_done (w_frame_done),
		.i_drdy_n (i_drdy_n),
		.o_capture (w_capture),
		.o_reg_rdata (o_reg_rdata),
		.o_busy (o_busy),
		.o_init_done (o_init_done),
		.o_spi_csn (o_spi_csn),
		.o_ads_resetn (o_ads_resetn),
		.o_ads_start (o_ads_start)
	);

endmodule

`default_nettype wire

//--- testbench/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

// 100 MHz clock, reset low for the first 3 cycles
module tb_clk_gen (
	output logic o_clk,
	output logic o_rstn
);

	initial begin
		o_clk = 1'b0;
		forever #5 o_clk = ~o_clk; // 10 ns period
	end

	initial begin
		o_rstn = 1'b0;
		repeat (3) @(posedge o_clk);
		@(negedge o_clk); // release away from the active edge
		o_rstn = 1'b1;
	end

endmodule

`default_nettype wire

//--- testbench/ads1292_model.sv
`timescale 1ns/1ps
`default_nettype none

// behavioral ADS1292, spi mode 1 slave oversampled on the system clock
module ads1292_model (
	input  logic i_clk,
	input  logic i_sclk,
	input  logic i_mosi,
	output logic o_miso,
	input  logic i_csn,
	output logic o_drdy_n,
	input  logic i_resetn,
	input  logic i_start
);

	localparam int DRDY_PERIOD = 600; // cycles between drdy falls
	localparam int DRDY_LOW = 20;

	logic [7:0] regs [0:31];
	logic [71:0] r_out; // miso shift, msb first
	logic [7:0] r_rx;
	logic [2:0] r_bit;
	logic [1:0] r_phase; // 0 opcode, 1 count, 2 data or dummy
	logic r_is_wreg;
	logic [4:0] r_addr;
	logic r_rdatac;
	logic r_sclk_q;
	logic [23:0] r_n; // frame number since start rose
	int r_drdy_cnt;

	// register reset value is addr ^ a5, chip wakes in rdatac
	task automatic chip_reset();
		int a;
		for (a = 0; a < 32; a++)
			regs[a] <= 8'(a) ^ 8'hA5;
		r_out <= '0;
		r_rx <= '0;
		r_bit <= '0;
		r_phase <= '0;
		r_is_wreg <= 1'b0;
		r_addr <= '0;
		r_rdatac <= 1'b1;
		r_n <= '0;
		r_drdy_cnt <= 0;
		o_miso <= 1'b0;
		o_drdy_n <= 1'b1;
	endtask

	// opcode decoder, one whole byte from MOSI
	task automatic take_byte(input logic [7:0] b);
		case (r_phase)
			2'd0: begin
				if (b[7:5] == 3'b010 || b[7:5] == 3'b001) begin // wreg or rreg
					r_is_wreg <= (b[7:5] == 3'b010);
					r_addr <= b[4:0];
					r_phase <= 2'd1;
				end else if (b == 8'h10) begin
					r_rdatac <= 1'b1;
				end else if (b == 8'h11) begin
					r_rdatac <= 1'b0;
				end
			end
			2'd1: begin // count byte, single register only
				if (!r_is_wreg)
					r_out[71:64] <= regs[r_addr]; // out during the next byte
				r_phase <= 2'd2;
			end
			default: begin
				if (r_is_wreg)
					regs[r_addr] <= b;
				r_phase <= 2'd0;
			end
		endcase
	endtask

	initial chip_reset();

	always @(posedge i_clk) begin
		r_sclk_q <= i_sclk;
		if (!i_resetn) begin
			chip_reset();
		end else begin
			// ==================================================
			// spi slave
			// ==================================================
			if (i_csn) begin
				r_bit <= '0;
			end else if (i_sclk && !r_sclk_q) begin // rising, next bit out
				o_miso <= r_out[71];
				r_out <= {r_out[70:0], 1'b0};
			end else if (!i_sclk && r_sclk_q) begin // falling, sample mosi
				r_rx <= {r_rx[6:0], i_mosi};
				r_bit <= r_bit + 1'b1;
				if (r_bit == 3'd7)
					take_byte({r_rx[6:0], i_mosi});
			end
			// drdy generator, runs only while start is high
			if (!i_start) begin
				r_drdy_cnt <= 0;
				r_n <= '0;
				o_drdy_n <= 1'b1;
			end else if (r_drdy_cnt == DRDY_PERIOD - 1) begin
				r_drdy_cnt <= 0;
				o_drdy_n <= 1'b0;
				if (r_rdatac)
					r_out <= {24'hC00000, r_n, ~r_n}; // status, ch1, ch2
				r_n <= r_n + 24'd1;
			end else begin
				r_drdy_cnt <= r_drdy_cnt + 1;
				if (r_drdy_cnt == DRDY_LOW - 1)
					o_drdy_n <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- testbench/tb_ads1292.sv
`timescale 1ns/1ps
`default_nettype none
`include "ads_params.svh"

module tb_ads1292;

	localparam int SIG_BUSY = 0;
	localparam int SIG_INIT = 1;
	localparam int SIG_DV = 2;

	typedef struct packed {
		ads_cmd_pkg::ctrl_e op;
		logic [7:0] addr;
		logic [7:0] wdata;
		logic [7:0] exp_val; // read data or frame count for rdatac
	} op_entry_t;

	logic clk;
	logic rstn;
	logic [2:0] ctrl;
	logic [7:0] reg_addr;
	logic [7:0] reg_wdata;
	logic [7:0] reg_rdata;
	ads_frame_pkg::ads_frame_t frame;
	logic data_valid;
	logic busy;
	logic init_done;
	logic spi_clk;
	logic spi_mosi;
	logic spi_miso;
	logic spi_csn;
	logic drdy_n;
	logic ads_resetn;
	logic ads_start;

	op_entry_t ops_q[$];
	logic [7:0] shadow [0:31]; // expected register file
	logic [7:0] lfsr;
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int dv_count = 0; // o_data_valid pulses so far
	int resetn_falls = 0;
	bit resetn_late = 1'b0; // reset pin pulsed after init

	tb_clk_gen u_clk (.o_clk(clk), .o_rstn(rstn));

	ads1292_ctrl_top dut (
		.i_CLK (clk),
		.i_RSTN (rstn),
		.i_ctrl (ctrl),
		.i_reg_addr (reg_addr),
		.i_reg_wdata (reg_wdata),
		.o_reg_rdata (reg_rdata),
		.o_frame (frame),
		.o_data_valid (data_valid),
		.o_busy (busy),
		.o_init_done (init_done),
		.o_spi_clk (spi_clk),
		.o_spi_mosi (spi_mosi),
		.i_spi_miso (spi_miso),
		.o_spi_csn (spi_csn),
		.i_drdy_n (drdy_n),
		.o_ads_resetn (ads_resetn),
		.o_ads_start (ads_start)
	);

	ads1292_model u_chip (
		.i_clk (clk),
		.i_sclk (spi_clk),
		.i_mosi (spi_mosi),
		.o_miso (spi_miso),
		.i_csn (spi_csn),
		.o_drdy_n (drdy_n),
		.i_resetn (ads_resetn),
		.i_start (ads_start)
	);

	always @(posedge clk)
		if (data_valid)
			dv_count <= dv_count + 1;

	always @(negedge ads_resetn) begin
		resetn_falls++;
		if (init_done)
			resetn_late = 1'b1;
	end

	// ==================================================
	// helpers
	// ==================================================
	// fibonacci lfsr with taps 8 6 5 4
	function automatic logic [7:0] lfsr_step(input logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
	endfunction

	task automatic next_rand_byte(output logic [7:0] b);
		int i;
		b = '0;
		for (i = 0; i < 8; i++) begin
			lfsr = lfsr_step(lfsr); // one step per bit
			b = {b[6:0], lfsr[0]};
		end
	endtask

	task automatic add_op(input ads_cmd_pkg::ctrl_e op, input logic [7:0] addr,
		input logic [7:0] frames);
		op_entry_t e;
		logic [7:0] wd;
		wd = '0;
		e.op = op;
		e.addr = addr;
		e.exp_val = frames;
		if (op == ads_cmd_pkg::CTRL_WREG) begin
			next_rand_byte(wd);
			shadow[addr[4:0]] = wd;
		end else if (op == ads_cmd_pkg::CTRL_RREG) begin
			e.exp_val = shadow[addr[4:0]]; // last write or the reset value
		end
		e.wdata = wd;
		ops_q.push_back(e);
	endtask

	function automatic logic probe_signal(input int sel);
		case (sel)
			SIG_BUSY: return busy;
			SIG_INIT: return init_done;
			default: return data_valid;
		endcase
	endfunction

	// polls on falling edges where outputs are settled
	task automatic wait_level(input int sel, input logic level, input int limit,
		input string what, output bit ok);
		int n;
		n = 0;
		while (probe_signal(sel) !== level && n < limit) begin
			@(negedge clk);
			n++;
		end
		ok = (probe_signal(sel) === level);
		if (!ok) begin
			$display("timeout: no %s within %0d cycles", what, limit);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input bit ok);
		tests_run++;
		if (!ok)
			tests_failed++;
		$display("test %0d %s: %s", tests_run, name, ok ? "pass" : "fail");
	endtask

	// ==================================================
	// one table entry
	// ==================================================
	task automatic run_op(input op_entry_t e, output bit ok);
		bit got;
		int first_err;
		int n;
		int dv_snap;
		ads_frame_pkg::ads_frame_t fr;
		logic [23:0] prev_ch1;
		first_err = errors;
		prev_ch1 = '0;
		@(negedge clk);
		ctrl = e.op;
		reg_addr = e.addr;
		reg_wdata = e.wdata;
		dv_snap = dv_count;
		wait_level(SIG_BUSY, 1'b1, 10, "o_busy rise", got);
		case (e.op)
			ads_cmd_pkg::CTRL_RDATAC: begin // code stays up while the read runs on
				for (n = 0; n < e.exp_val && got; n++) begin
					@(negedge clk); // step past the last pulse
					wait_level(SIG_DV, 1'b1, 5000, "o_data_valid pulse", got);
					fr = frame;
					if (got) begin
						assert (fr.status == 24'hC00000 && fr.ch2 == ~fr.ch1) else begin
							$display("FAILED at %0t: frame %06h %06h %06h malformed",
								$time, fr.status, fr.ch1, fr.ch2);
							errors++;
						end
						if (n == 0) begin
							assert (fr.ch1 >= `ADS_SETTLE_DRDY) else begin
								$display("FAILED at %0t: first ch1 %0d is an unsettled frame",
									$time, fr.ch1);
								errors++;
							end
						end else begin
							assert (fr.ch1 == prev_ch1 + 24'd1) else begin
								$display("FAILED at %0t: ch1 %0d after %0d", $time, fr.ch1,
									prev_ch1);
								errors++;
							end
						end
						prev_ch1 = fr.ch1;
					end
				end
			end
			ads_cmd_pkg::CTRL_SDATAC: begin
				wait_level(SIG_BUSY, 1'b0, 2000, "o_busy fall after stop", got);
				ctrl = ads_cmd_pkg::CTRL_IDLE;
				assert (ads_start == 1'b0) else begin
					$display("FAILED at %0t: o_ads_start still high", $time);
					errors++;
				end
				repeat (2000) @(negedge clk); // quiet window
				assert (dv_count == dv_snap) else begin
					$display("FAILED at %0t: %0d frames after stop", $time,
						dv_count - dv_snap);
					errors++;
				end
			end
			default: begin // wreg, rreg
				wait_level(SIG_BUSY, 1'b0, 1000, "o_busy fall", got);
				ctrl = ads_cmd_pkg::CTRL_IDLE;
				if (e.op == ads_cmd_pkg::CTRL_RREG) begin
					assert (reg_rdata == e.exp_val) else begin
						$display("FAILED at %0t: rreg %02h got %02h expected %02h", $time,
							e.addr, reg_rdata, e.exp_val);
						errors++;
					end
				end
			end
		endcase
		ok = (errors == first_err);
	endtask

	// ==================================================
	// stimulus
	// ==================================================
	initial begin
		bit ok;
		int i;
		int first_err;
		ads_cmd_pkg::ctrl_e op;
		ctrl = ads_cmd_pkg::CTRL_IDLE;
		reg_addr = '0;
		reg_wdata = '0;
		lfsr = 8'd18; // seed
		for (i = 0; i < 32; i++)
			shadow[i] = 8'(i) ^ 8'hA5;

		add_op(ads_cmd_pkg::CTRL_RREG, 8'h03, 8'd0); // never written
		add_op(ads_cmd_pkg::CTRL_WREG, 8'h05, 8'd0);
		add_op(ads_cmd_pkg::CTRL_RREG, 8'h05, 8'd0);
		add_op(ads_cmd_pkg::CTRL_RREG, 8'h06, 8'd0); // neighbour untouched
		add_op(ads_cmd_pkg::CTRL_WREG, 8'h1F, 8'd0);
		add_op(ads_cmd_pkg::CTRL_RREG, 8'h1F, 8'd0);
		add_op(ads_cmd_pkg::CTRL_RDATAC, 8'h00, 8'd4); // four frames
		add_op(ads_cmd_pkg::CTRL_SDATAC, 8'h00, 8'd0);
		add_op(ads_cmd_pkg::CTRL_RREG, 8'h05, 8'd0);

		// power-up sequence
		first_err = errors;
		@(negedge clk);
		wait_level(SIG_INIT, 1'b1, 3000, "o_init_done", ok);
		assert (resetn_falls == 1) else begin
			$display("FAILED at %0t: reset pin pulsed %0d times", $time, resetn_falls);
			errors++;
		end
		assert (!busy && spi_csn && !ads_start) else begin
			$display("FAILED at %0t: busy %b csn %b start %b after init", $time, busy,
				spi_csn, ads_start);
			errors++;
		end
		report_test("power-up", errors == first_err);

		for (i = 0; i < ops_q.size(); i++) begin
			run_op(ops_q[i], ok);
			op = ops_q[i].op;
			report_test($sformatf("%s addr %02h", op.name(), ops_q[i].addr), ok);
		end

		// reset pin stays high once the chip is up
		assert (!resetn_late) else begin
			$display("FAILED at %0t: reset pin pulsed again after init", $time);
			errors++;
		end

		$display("%0d tests, %0d passed, %0d failed, %0d errors", tests_run,
			tests_run - tests_failed, tests_failed, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+hw
hw/ads_frame_pkg.sv
hw/ads_cmd_pkg.sv
hw/spi_byte_if.sv
hw/spi_master.sv
hw/ads_frame_capture.sv
hw/ads_sequencer.sv
hw/ads1292_ctrl_top.sv
testbench/tb_clk_gen.sv
testbench/ads1292_model.sv
testbench/tb_ads1292.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the ADS1292 controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_ads1292 \
	--Mdir obj_dir -o tb_ads1292 \
	&& ./obj_dir/tb_ads1292 > "$LOG" 2>&1 \
	|| echo "build or simulation did not complete"

cat "$LOG" 2>/dev/null
grep -qF "*** TEST PASSED ***" "$LOG" && exit 0 || exit 1
